// ==== src/vga_logo_pkg.sv ====
package vga_logo_pkg;

   // ------------------------------
   // basic widths
   // ------------------------------

   // pixel coordinate, x and y alike
   typedef logic [9:0] coord_t;
   // one bit per colour: red, green, blue
   typedef logic [2:0] rgb_t;
   // digit selector, 0 to 9
   typedef logic [3:0] glyph_id_t;

   // ------------------------------
   // 640x480 screen timing
   // ------------------------------
   localparam int H_DISPLAY = 640;
   localparam int H_FRONT   = 16;
   localparam int H_SYNC    = 96;
   localparam int H_BACK    = 48;
   localparam int H_TOTAL   = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;

   localparam int V_DISPLAY = 480;
   localparam int V_FRONT   = 10;
   localparam int V_SYNC    = 2;
   localparam int V_BACK    = 33;
   localparam int V_TOTAL   = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;

   // glyph bitmap size
   localparam int GLYPH_W = 32;
   localparam int GLYPH_H = 16;

   // one bitmap row, bit 31 is the leftmost pixel
   typedef logic [GLYPH_W-1:0] glyph_row_t;

   // beam state from the sync unit
   typedef struct packed {
      coord_t pix_x;
      coord_t pix_y;
      logic   video_on;
      logic   hsync;
      logic   vsync;
      logic   refr_tick;
   } vga_timing_t;

   // sprite verdict for the current pixel
   typedef struct packed {
      logic on;
      rgb_t rgb;
   } sprite_hit_t;

endpackage

// ==== src/vga_sync.sv ====
`timescale 1ns/1ps

module vga_sync
(
   input  logic                      clk,
   input  logic                      reset,
   output vga_logo_pkg::vga_timing_t beam
);

   import vga_logo_pkg::*;

   // ------------------------------
   // counter limits and sync windows
   // ------------------------------
   localparam coord_t H_LAST       = coord_t'(H_TOTAL - 1);
   localparam coord_t V_LAST       = coord_t'(V_TOTAL - 1);
   localparam coord_t H_VISIBLE    = coord_t'(H_DISPLAY);
   localparam coord_t V_VISIBLE    = coord_t'(V_DISPLAY);

   // hsync low over pixels 656 to 751
   localparam coord_t H_SYNC_FIRST = coord_t'(H_DISPLAY + H_FRONT);
   localparam coord_t H_SYNC_LAST  = coord_t'(H_DISPLAY + H_FRONT + H_SYNC - 1);

   // vsync low over lines 490 and 491
   localparam coord_t V_SYNC_FIRST = coord_t'(V_DISPLAY + V_FRONT);
   localparam coord_t V_SYNC_LAST  = coord_t'(V_DISPLAY + V_FRONT + V_SYNC - 1);

   coord_t h_cnt;
   coord_t v_cnt;
   logic   h_end;
   logic   v_end;

   // end of line, end of frame
   assign h_end = (h_cnt == H_LAST);
   assign v_end = (v_cnt == V_LAST);

   // ------------------------------
   // pixel counter, one step per clock
   // ------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         h_cnt <= '0;
      end
      else if (h_end)
      begin
         h_cnt <= '0;
      end
      else
      begin
         h_cnt <= h_cnt + 10'd1;
      end
   end

   // line counter, steps at end of each line
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         v_cnt <= '0;
      end
      else if (h_end)
      begin
         if (v_end)
         begin
            v_cnt <= '0;
         end
         else
         begin
            v_cnt <= v_cnt + 10'd1;
         end
      end
   end

   // ------------------------------
   // beam state, same cycle as counters
   // ------------------------------
   always_comb
   begin
      beam.pix_x     = h_cnt;
      beam.pix_y     = v_cnt;
      beam.video_on  = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
      // syncs are active low
      beam.hsync     = ~((h_cnt >= H_SYNC_FIRST) && (h_cnt <= H_SYNC_LAST));
      beam.vsync     = ~((v_cnt >= V_SYNC_FIRST) && (v_cnt <= V_SYNC_LAST));
      // first pixel of vertical blanking
      beam.refr_tick = (h_cnt == '0) && (v_cnt == V_VISIBLE);
   end

endmodule

// ==== src/glyph_sprite.sv ====
`timescale 1ns/1ps

module glyph_sprite
#(
   parameter vga_logo_pkg::glyph_id_t GLYPH   = 4'd8,
   parameter vga_logo_pkg::coord_t    X_START = 10'd300,
   parameter vga_logo_pkg::coord_t    Y_START = 10'd10,
   parameter vga_logo_pkg::rgb_t      COLOUR  = 3'b101
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      freeze,
   input  vga_logo_pkg::vga_timing_t beam,
   output vga_logo_pkg::sprite_hit_t hit
);

   import vga_logo_pkg::*;

   localparam int ROW_W = $clog2(GLYPH_H);
   localparam int COL_W = $clog2(GLYPH_W);

   // top-left corner limits, 608 and 464
   localparam coord_t X_MAX = coord_t'(H_DISPLAY - GLYPH_W);
   localparam coord_t Y_MAX = coord_t'(V_DISPLAY - GLYPH_H);

   // position and direction of one axis, dir 1 counts up
   typedef struct packed {
      logic   dir;
      coord_t pos;
   } axis_t;

   // ------------------------------
   // glyph ROM
   // ------------------------------

   // segment mask a..g in bits 6..0
   function automatic logic [6:0] seg_lookup(input glyph_id_t id);
      logic [6:0] seg;
      case (id)
         4'd0:    seg = 7'b1111110;
         4'd1:    seg = 7'b0110000;
         4'd2:    seg = 7'b1101101;
         4'd3:    seg = 7'b1111001;
         4'd4:    seg = 7'b0110011;
         4'd5:    seg = 7'b1011011;
         4'd6:    seg = 7'b1011111;
         4'd7:    seg = 7'b1110000;
         4'd8:    seg = 7'b1111111;
         4'd9:    seg = 7'b1111011;
         default: seg = 7'b0000000;
      endcase
      return seg;
   endfunction

   localparam logic [6:0] SEG = seg_lookup(GLYPH);

   // outline pieces, three pixel strokes
   localparam glyph_row_t ROW_CAP   = glyph_row_t'(32'h3FF) << 11;
   localparam glyph_row_t ROW_WIDE  = glyph_row_t'(32'hFFF) << 10;
   localparam glyph_row_t ROW_LEFT  = glyph_row_t'(32'h7) << 19;
   localparam glyph_row_t ROW_RIGHT = glyph_row_t'(32'h7) << 10;

   // upper half uses f and b, lower half e and c
   localparam glyph_row_t ROW_UPPER = (SEG[1] ? ROW_LEFT : '0) | (SEG[5] ? ROW_RIGHT : '0);
   localparam glyph_row_t ROW_LOWER = (SEG[2] ? ROW_LEFT : '0) | (SEG[4] ? ROW_RIGHT : '0);

   logic [ROW_W-1:0] rom_addr;
   logic [COL_W-1:0] rom_col;
   glyph_row_t       rom_data;

   always_comb
   begin
      case (rom_addr)
         // top bar, rounded by the wide row under it
         4'd0:    rom_data = SEG[6] ? ROW_CAP : '0;
         4'd1:    rom_data = SEG[6] ? ROW_WIDE : ROW_UPPER;
         // middle bar is two rows thick
         4'd7:    rom_data = SEG[0] ? ROW_CAP : ROW_UPPER;
         4'd8:    rom_data = SEG[0] ? ROW_CAP : ROW_LOWER;
         // bottom bar
         4'd14:   rom_data = SEG[3] ? ROW_WIDE : ROW_LOWER;
         4'd15:   rom_data = SEG[3] ? ROW_CAP : '0;
         default: rom_data = (rom_addr < 4'd7) ? ROW_UPPER : ROW_LOWER;
      endcase
   end

   // ------------------------------
   // motion with edge bounce
   // ------------------------------
   function automatic axis_t bounce(input axis_t cur, input coord_t lim);
      axis_t nxt;
      nxt = cur;
      if (cur.dir)
      begin
         // past the far edge, turn back
         nxt.dir = (cur.pos < lim);
         nxt.pos = (cur.pos < lim) ? cur.pos + 10'd1 : cur.pos - 10'd1;
      end
      else
      begin
         nxt.dir = (cur.pos == '0);
         nxt.pos = (cur.pos == '0) ? 10'd1 : cur.pos - 10'd1;
      end
      return nxt;
   endfunction

   axis_t x_axis;
   axis_t y_axis;

   // new position takes effect next frame
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         x_axis <= '{dir: 1'b1, pos: X_START};
         y_axis <= '{dir: 1'b1, pos: Y_START};
      end
      else if (beam.refr_tick && !freeze)
      begin
         x_axis <= bounce(x_axis, X_MAX);
         y_axis <= bounce(y_axis, Y_MAX);
      end
   end

   // ------------------------------
   // pixel hit test
   // ------------------------------
   coord_t dx;
   coord_t dy;
   logic   in_box;

   assign dx     = beam.pix_x - x_axis.pos;
   assign dy     = beam.pix_y - y_axis.pos;
   assign in_box = (beam.pix_x >= x_axis.pos) && (dx < coord_t'(GLYPH_W)) &&
                   (beam.pix_y >= y_axis.pos) && (dy < coord_t'(GLYPH_H));

   // bit 31 on the left edge of the box
   assign rom_addr = dy[ROW_W-1:0];
   assign rom_col  = COL_W'(GLYPH_W - 1) - dx[COL_W-1:0];

   always_comb
   begin
      hit.on  = in_box && rom_data[rom_col];
      hit.rgb = COLOUR;
   end

endmodule

// ==== src/rgb_mux.sv ====
`timescale 1ns/1ps

module rgb_mux
#(
   parameter vga_logo_pkg::rgb_t BG_COLOUR = 3'b001
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  vga_logo_pkg::vga_timing_t beam,
   input  vga_logo_pkg::sprite_hit_t hit_a,
   input  vga_logo_pkg::sprite_hit_t hit_b,
   output logic                      hsync,
   output logic                      vsync,
   output logic                      frame_tick,
   output vga_logo_pkg::rgb_t        rgb
);

   import vga_logo_pkg::*;

   rgb_t rgb_next;

   // ------------------------------
   // colour select
   // ------------------------------
   always_comb
   begin
      if (!beam.video_on)
      begin
         // blanking interval is black
         rgb_next = '0;
      end
      else if (hit_a.on)
      begin
         // sprite a sits in front
         rgb_next = hit_a.rgb;
      end
      else if (hit_b.on)
      begin
         rgb_next = hit_b.rgb;
      end
      else
      begin
         rgb_next = BG_COLOUR;
      end
   end

   // ------------------------------
   // output register
   // ------------------------------
   // colour, syncs and tick leave together, one cycle behind the counters
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rgb        <= '0;
         hsync      <= 1'b1;
         vsync      <= 1'b1;
         frame_tick <= 1'b0;
      end
      else
      begin
         rgb        <= rgb_next;
         hsync      <= beam.hsync;
         vsync      <= beam.vsync;
         frame_tick <= beam.refr_tick;
      end
   end

endmodule

// ==== src/logo_display_top.sv ====
`timescale 1ns/1ps

module logo_display_top
#(
   // front sprite, digit 8
   parameter vga_logo_pkg::coord_t EIGHT_X_START = 10'd300,
   parameter vga_logo_pkg::coord_t EIGHT_Y_START = 10'd10,
   parameter vga_logo_pkg::rgb_t   EIGHT_COLOUR  = 3'b101,
   // rear sprite, digit 0
   parameter vga_logo_pkg::coord_t ZERO_X_START  = 10'd100,
   parameter vga_logo_pkg::coord_t ZERO_Y_START  = 10'd200,
   parameter vga_logo_pkg::rgb_t   ZERO_COLOUR   = 3'b011,
   parameter vga_logo_pkg::rgb_t   BG_COLOUR     = 3'b001
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               freeze,
   output logic               hsync,
   output logic               vsync,
   output logic               frame_tick,
   output vga_logo_pkg::rgb_t rgb
);

   import vga_logo_pkg::*;

   vga_timing_t beam;
   sprite_hit_t hit_a;
   sprite_hit_t hit_b;

   // beam position and syncs
   vga_sync sync_unit
   (
      .clk   (clk),
      .reset (reset),
      .beam  (beam)
   );

   // ------------------------------
   // sprites, a wins on overlap
   // ------------------------------
   glyph_sprite
   #(
      .GLYPH   (4'd8),
      .X_START (EIGHT_X_START),
      .Y_START (EIGHT_Y_START),
      .COLOUR  (EIGHT_COLOUR)
   )
   digit_eight
   (
      .clk    (clk),
      .reset  (reset),
      .freeze (freeze),
      .beam   (beam),
      .hit    (hit_a)
   );

   glyph_sprite
   #(
      .GLYPH   (4'd0),
      .X_START (ZERO_X_START),
      .Y_START (ZERO_Y_START),
      .COLOUR  (ZERO_COLOUR)
   )
   digit_zero
   (
      .clk    (clk),
      .reset  (reset),
      .freeze (freeze),
      .beam   (beam),
      .hit    (hit_b)
   );

   // priority, blanking and output register
   rgb_mux
   #(
      .BG_COLOUR (BG_COLOUR)
   )
   mux
   (
      .clk        (clk),
      .reset      (reset),
      .beam       (beam),
      .hit_a      (hit_a),
      .hit_b      (hit_b),
      .hsync      (hsync),
      .vsync      (vsync),
      .frame_tick (frame_tick),
      .rgb        (rgb)
   );

endmodule

// ==== tb/logo_display_props.sv ====
`timescale 1ns/1ps

module logo_display_props
(
   input logic               clk,
   input logic               reset,
   input logic               video_on,
   input vga_logo_pkg::rgb_t rgb,
   input logic               frame_tick
);

   // ------------------------------
   // blanking
   // ------------------------------

   // blanked pixel comes out black one cycle later
   blank_black: assert property (@(posedge clk) disable iff (reset)
      !$past(video_on) |-> (rgb == '0))
   else $error("rgb not black after a blanked pixel");

   // ------------------------------
   // frame pulse
   // ------------------------------

   // one clock wide, never two in a row
   tick_single: assert property (@(posedge clk) disable iff (reset)
      frame_tick |=> !frame_tick)
   else $error("frame_tick high for more than one cycle");

endmodule

// watch the output register of the mux
bind rgb_mux logo_display_props props
(
   .clk        (clk),
   .reset      (reset),
   .video_on   (beam.video_on),
   .rgb        (rgb),
   .frame_tick (frame_tick)
);

// ==== tb/logo_display_tb.sv ====
`timescale 1ns/1ps

module logo_display_tb;

   import vga_logo_pkg::*;

   // ------------------------------
   // setup
   // ------------------------------
   localparam int     CLK_PERIOD   = 20;
   localparam int     RESET_CYCLES = 8;
   localparam int     FRAME_CYCLES = H_TOTAL * V_TOTAL;
   // ten frames of tests, two spare for the bounce loop
   localparam int     RUN_FRAMES   = 12;
   localparam longint WATCHDOG_NS  = longint'(RUN_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD;

   // top-left limits of a 32x16 box
   localparam int X_LIMIT = H_DISPLAY - GLYPH_W;
   localparam int Y_LIMIT = V_DISPLAY - GLYPH_H;

   // sync windows
   localparam int H_SYNC_START = H_DISPLAY + H_FRONT;
   localparam int H_SYNC_END   = H_DISPLAY + H_FRONT + H_SYNC - 1;
   localparam int V_SYNC_START = V_DISPLAY + V_FRONT;
   localparam int V_SYNC_END   = V_DISPLAY + V_FRONT + V_SYNC - 1;

   // eight starts low so it meets the bottom edge within the run
   localparam int   EIGHT_X0  = 300;
   localparam int   EIGHT_Y0  = 458;
   // zero sits up and to the right, its lower half behind the eight
   localparam int   ZERO_X0   = 310;
   localparam int   ZERO_Y0   = 450;
   localparam rgb_t EIGHT_RGB = 3'b101;
   localparam rgb_t ZERO_RGB  = 3'b011;
   localparam rgb_t BG_RGB    = 3'b001;

   logic clk;
   logic reset;
   logic freeze;
   logic hsync;
   logic vsync;
   logic frame_tick;
   rgb_t rgb;

   // model beam, the pixel now at the outputs
   int   m_h;
   int   m_v;
   // sprite 0 is the eight, sprite 1 the zero
   int   pos_x [2];
   int   pos_y [2];
   int   dir_x [2];
   int   dir_y [2];
   // per frame observations
   int   top_eight;
   int   top_zero;
   int   cnt_eight;
   int   cnt_zero;
   bit   obs_hsync;
   bit   obs_vsync;
   bit   obs_tick;
   bit   record_frame;
   bit   compare_frame;
   rgb_t frame_buf [H_DISPLAY * V_DISPLAY];
   int   error_count;

   logo_display_top
   #(
      .EIGHT_X_START (coord_t'(EIGHT_X0)),
      .EIGHT_Y_START (coord_t'(EIGHT_Y0)),
      .EIGHT_COLOUR  (EIGHT_RGB),
      .ZERO_X_START  (coord_t'(ZERO_X0)),
      .ZERO_Y_START  (coord_t'(ZERO_Y0)),
      .ZERO_COLOUR   (ZERO_RGB),
      .BG_COLOUR     (BG_RGB)
   )
   UUT
   (
      .clk        (clk),
      .reset      (reset),
      .freeze     (freeze),
      .hsync      (hsync),
      .vsync      (vsync),
      .frame_tick (frame_tick),
      .rgb        (rgb)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------
   // reporting
   // ------------------------------
   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         error_count++;
         $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
         report_failure({"mismatch on ", name});
      end
   endtask

   // ------------------------------
   // reference model
   // ------------------------------

   // outline digits, bit 31 leftmost, 8 differs from 0 only in the middle bar
   function automatic logic [31:0] bitmap_row(input bit eight, input int row);
      logic [31:0] bits;
      case (row)
         0, 15:   bits = 32'h001F_F800;
         1, 14:   bits = 32'h003F_FC00;
         7, 8:    bits = eight ? 32'h001F_F800 : 32'h0038_1C00;
         default: bits = 32'h0038_1C00;
      endcase
      return bits;
   endfunction

   function automatic bit sprite_lit(input bit s, input int h, input int v);
      int          col;
      int          row;
      logic [31:0] bits;
      col = h - pos_x[s];
      row = v - pos_y[s];
      if (col < 0 || col >= GLYPH_W || row < 0 || row >= GLYPH_H)
      begin
         return 1'b0;
      end
      bits = bitmap_row(s == 1'b0, row);
      return bits[5'(GLYPH_W - 1 - col)];
   endfunction

   // eight in front, then zero, then background
   function automatic rgb_t expected_rgb(input int h, input int v);
      if (h >= H_DISPLAY || v >= V_DISPLAY)
      begin
         return '0;
      end
      else if (sprite_lit(1'b0, h, v))
      begin
         return EIGHT_RGB;
      end
      else if (sprite_lit(1'b1, h, v))
      begin
         return ZERO_RGB;
      end
      return BG_RGB;
   endfunction

   function automatic bit expected_hsync(input int h);
      return !(h >= H_SYNC_START && h <= H_SYNC_END);
   endfunction

   function automatic bit expected_vsync(input int v);
      return !(v >= V_SYNC_START && v <= V_SYNC_END);
   endfunction

   // leaving 0..limit turns the axis and steps back
   task automatic move_sprite(input bit s);
      if (pos_x[s] + dir_x[s] < 0 || pos_x[s] + dir_x[s] > X_LIMIT)
      begin
         dir_x[s] = -dir_x[s];
      end
      if (pos_y[s] + dir_y[s] < 0 || pos_y[s] + dir_y[s] > Y_LIMIT)
      begin
         dir_y[s] = -dir_y[s];
      end
      pos_x[s] = pos_x[s] + dir_x[s];
      pos_y[s] = pos_y[s] + dir_y[s];
   endtask

   // one clock, compare at the falling edge, then advance the model
   task automatic step_and_check(input bit sparse);
      logic [18:0] idx;
      @(negedge clk);
      if (m_h == 0 && m_v == 0)
      begin
         top_eight = -1;
         top_zero  = -1;
         cnt_eight = 0;
         cnt_zero  = 0;
      end
      check_value("hsync", 32'(hsync), 32'(expected_hsync(m_h)));
      check_value("vsync", 32'(vsync), 32'(expected_vsync(m_v)));
      check_value("frame_tick", 32'(frame_tick), 32'(m_h == 0 && m_v == V_DISPLAY));
      // sparse mode checks every eighth row only
      if (!sparse || (m_v % 8) == 0)
      begin
         check_value("rgb", 32'(rgb), 32'(expected_rgb(m_h, m_v)));
      end
      obs_hsync = hsync;
      obs_vsync = vsync;
      obs_tick  = frame_tick;
      if (m_h < H_DISPLAY && m_v < V_DISPLAY)
      begin
         idx = 19'(m_v * H_DISPLAY + m_h);
         if (rgb == EIGHT_RGB)
         begin
            cnt_eight++;
            if (top_eight < 0)
            begin
               top_eight = m_v;
            end
         end
         if (rgb == ZERO_RGB)
         begin
            cnt_zero++;
            if (top_zero < 0)
            begin
               top_zero = m_v;
            end
         end
         if (record_frame)
         begin
            frame_buf[idx] = rgb;
         end
         if (compare_frame)
         begin
            check_value("rgb against frozen frame", 32'(rgb), 32'(frame_buf[idx]));
         end
      end
      // positions step at the tick pixel unless frozen
      if (m_h == 0 && m_v == V_DISPLAY && !freeze)
      begin
         move_sprite(1'b0);
         move_sprite(1'b1);
      end
      if (m_h == H_TOTAL - 1)
      begin
         m_h = 0;
         m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
      end
      else
      begin
         m_h++;
      end
   endtask

   // from frame start to the next frame start
   task automatic run_frame(input bit sparse);
      do
      begin
         step_and_check(sparse);
      end
      while (!(m_h == 0 && m_v == 0));
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic after_reset_state();
      int cycles;
      reset = 1'b1;
      repeat (RESET_CYCLES)
      begin
         @(negedge clk);
         check_value("hsync in reset", 32'(hsync), 32'd1);
         check_value("vsync in reset", 32'(vsync), 32'd1);
         check_value("rgb in reset", 32'(rgb), 32'd0);
         check_value("frame_tick in reset", 32'(frame_tick), 32'd0);
      end
      reset  = 1'b0;
      cycles = 0;
      obs_tick = 1'b0;
      while (!obs_tick)
      begin
         if (cycles > FRAME_CYCLES)
         begin
            report_failure("frame_tick never came after reset release");
         end
         else
         begin
            step_and_check(1'b0);
            cycles++;
         end
      end
      check_value("cycles to first frame_tick", 32'(cycles), 32'(V_DISPLAY * H_TOTAL + 1));
      while (!(m_h == 0 && m_v == 0))
      begin
         step_and_check(1'b0);
      end
   endtask

   task automatic sync_pulse_timing();
      int h;
      int v;
      int hs_low;
      int vs_low;
      int first_hs;
      int last_hs;
      int first_vs;
      hs_low   = 0;
      vs_low   = 0;
      first_hs = -1;
      last_hs  = -1;
      first_vs = -1;
      do
      begin
         h = m_h;
         v = m_v;
         step_and_check(1'b0);
         if (!obs_hsync)
         begin
            hs_low++;
            if (v == 0)
            begin
               if (first_hs < 0)
               begin
                  first_hs = h;
               end
               last_hs = h;
            end
         end
         if (!obs_vsync)
         begin
            vs_low++;
            if (first_vs < 0)
            begin
               first_vs = v;
            end
         end
      end
      while (!(m_h == 0 && m_v == 0));
      check_value("hsync low cycles per frame", 32'(hs_low), 32'(H_SYNC * V_TOTAL));
      check_value("hsync first low pixel", 32'(first_hs), 32'(H_SYNC_START));
      check_value("hsync last low pixel", 32'(last_hs), 32'(H_SYNC_END));
      check_value("vsync low cycles per frame", 32'(vs_low), 32'(V_SYNC * H_TOTAL));
      check_value("vsync first low line", 32'(first_vs), 32'(V_SYNC_START));
   endtask

   task automatic pixel_colours();
      int lit_eight;
      int lit_zero;
      lit_eight = 0;
      lit_zero  = 0;
      for (int row = 0; row < GLYPH_H; row++)
      begin
         lit_eight += $countones(bitmap_row(1'b1, row));
      end
      // zero pixels the eight leaves uncovered
      for (int row = 0; row < GLYPH_H; row++)
      begin
         for (int col = 0; col < GLYPH_W; col++)
         begin
            if (sprite_lit(1'b1, pos_x[1] + col, pos_y[1] + row) &&
                !sprite_lit(1'b0, pos_x[1] + col, pos_y[1] + row))
            begin
               lit_zero++;
            end
         end
      end
      run_frame(1'b0);
      // both sprites fully on screen, the eight hides part of the zero
      check_value("digit_eight pixel count", 32'(cnt_eight), 32'(lit_eight));
      check_value("digit_zero pixel count", 32'(cnt_zero), 32'(lit_zero));
   endtask

   task automatic diagonal_motion();
      int prev_eight;
      int prev_zero;
      prev_eight = top_eight;
      prev_zero  = top_zero;
      repeat (2)
      begin
         run_frame(1'b0);
         check_value("digit_eight top row", 32'(top_eight), 32'(prev_eight + 1));
         check_value("digit_zero top row", 32'(top_zero), 32'(prev_zero + 1));
         prev_eight = top_eight;
         prev_zero  = top_zero;
      end
   endtask

   task automatic freeze_hold();
      int frozen_top;
      freeze       = 1'b1;
      record_frame = 1'b1;
      run_frame(1'b0);
      record_frame  = 1'b0;
      frozen_top    = top_eight;
      compare_frame = 1'b1;
      run_frame(1'b0);
      // released before this frame's tick, picture still the same
      freeze = 1'b0;
      run_frame(1'b0);
      compare_frame = 1'b0;
      run_frame(1'b0);
      check_value("digit_eight top row after freeze", 32'(top_eight), 32'(frozen_top + 1));
   endtask

   task automatic edge_bounce();
      int prev_top;
      int frames;
      bit turned;
      prev_top = top_eight;
      frames   = 0;
      turned   = 1'b0;
      while (!turned)
      begin
         if (frames == 3)
         begin
            report_failure("digit_eight never turned back at the bottom edge");
         end
         else
         begin
            run_frame(1'b1);
            frames++;
            if (top_eight < prev_top)
            begin
               // last frame sat on the limit
               turned = 1'b1;
               check_value("digit_eight y at the edge", 32'(prev_top), 32'(Y_LIMIT));
               check_value("digit_eight y after bounce", 32'(top_eight), 32'(Y_LIMIT - 1));
            end
            else
            begin
               check_value("digit_eight y step", 32'(top_eight), 32'(prev_top + 1));
            end
            prev_top = top_eight;
         end
      end
   endtask

   // ------------------------------
   // main sequence and watchdog
   // ------------------------------
   initial
   begin
      reset         = 1'b1;
      freeze        = 1'b0;
      error_count   = 0;
      record_frame  = 1'b0;
      compare_frame = 1'b0;
      m_h           = 0;
      m_v           = 0;
      pos_x[0]      = EIGHT_X0;
      pos_y[0]      = EIGHT_Y0;
      pos_x[1]      = ZERO_X0;
      pos_y[1]      = ZERO_Y0;
      // both sprites head right and down after reset
      dir_x[0]      = 1;
      dir_y[0]      = 1;
      dir_x[1]      = 1;
      dir_y[1]      = 1;
      after_reset_state();
      sync_pulse_timing();
      pixel_colours();
      diagonal_motion();
      freeze_hold();
      edge_bounce();
      if (error_count == 0)
      begin
         $display("No errors");
         $finish;
      end
      else
      begin
         report_failure("checks failed during the run");
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      report_failure("watchdog expired before the tests finished");
   end

endmodule

// ==== sources.f ====
src/vga_logo_pkg.sv
src/vga_sync.sv
src/glyph_sprite.sv
src/rgb_mux.sv
src/logo_display_top.sv
tb/logo_display_props.sv
tb/logo_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the logo display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sources.f \
   --top-module logo_display_tb \
   -o logo_display_sim

./obj_dir/logo_display_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
   echo "simulation failed"
   exit 1
fi

if ! grep -q "No errors" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

echo "simulation passed"
